//--- vlog.f
design/energy_pkg.sv
design/stream_stage.sv
design/monitor_ctrl.sv
design/row_counter.sv
design/spin_cache.sv
design/local_energy_calc.sv
design/energy_accumulator.sv
design/energy_monitor.sv
verif/energy_monitor_tb.sv

//--- Makefile
# Verilator simulation of the energy monitor

VERILATOR ?= verilator
TOP       ?= energy_monitor_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# the log is searched for the pass line, so a failing run fails the target
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/energy_monitor_tb.sv
/* Testbench of the energy monitor that runs frames through the stream ports
   and compares frame energy and overflow flag with a reference model. */
`default_nettype none

module energy_monitor_tb;

    localparam int DRV     = 2;   // drive delay after the rising edge
    localparam int TIMEOUT = 100; // cycles allowed per wait
    localparam int E_MAX   = 2**(energy_pkg::ENERGY_TOTAL_BIT-1) - 1;
    localparam int J_MAX   = 2**(energy_pkg::BITJ-1) - 1;
    localparam int H_MAX   = 2**(energy_pkg::BITH-1) - 1;

    logic                               clk_i = 1'b0;
    logic                               rst_i;
    logic                               en_i;
    logic                               config_valid_i;
    logic [energy_pkg::SPINIDX_BIT-1:0] config_counter_i;
    logic                               config_ready_o;
    logic                               spin_valid_i;
    energy_pkg::spin_vec_t              spin_i;
    logic                               spin_ready_o;
    logic                               weight_valid_i;
    energy_pkg::weight_row_t            weight_i;
    logic                               weight_ready_o;
    logic                               energy_valid_o;
    energy_pkg::energy_t                energy_o;
    logic                               accum_overflow_o;
    logic                               energy_ready_i;

    int                      seed;
    int                      errors = 0;
    int                      checks = 0;
    int                      tests = 0;
    int                      test_err0;
    string                   test_name;
    energy_pkg::spin_vec_t   frame_spin;
    energy_pkg::weight_row_t frame_rows [energy_pkg::DATASPIN];
    int                      row_next; // next row of the frame to offer
    energy_pkg::energy_t     got_energy;
    logic                    got_ovf;
    energy_pkg::energy_t     exp_energy;
    logic                    exp_ovf;

    energy_monitor DUT (.*);

    always #20 clk_i = ~clk_i;

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s finished, %0d errors", test_name, errors - test_err0);
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            $display("Fail %s %s expected %0d actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endtask

    function automatic logic ready_of(input int sel);
        return (sel == 0) ? config_ready_o : ((sel == 1) ? spin_ready_o : weight_ready_o);
    endfunction

    // waits for ready on input sel and transfers on the next edge
    task automatic wait_accept(input int sel, input string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!ready_of(sel) && n < TIMEOUT) begin
            n++;
            @(negedge clk_i);
        end
        checks++;
        assert (ready_of(sel)) else begin
            $display("%s: %s ready never rose", test_name, what);
            errors++;
        end
        @(posedge clk_i);
        #DRV;
        case (sel)
            0:       config_valid_i = 1'b0;
            1:       spin_valid_i   = 1'b0;
            default: weight_valid_i = 1'b0;
        endcase
    endtask

    task automatic fill_frame(input bit max_vals);
        frame_spin = max_vals ? '1 : energy_pkg::spin_vec_t'($random(seed));
        row_next   = 0;
        for (int i = 0; i < energy_pkg::DATASPIN; i++) begin
            for (int j = 0; j < energy_pkg::DATASPIN; j++) begin
                frame_rows[i].j_row[j*energy_pkg::BITJ +: energy_pkg::BITJ] = max_vals ?
                    energy_pkg::BITJ'(J_MAX) : energy_pkg::BITJ'($random(seed) % 3);
            end
            frame_rows[i].hbias = max_vals ?
                energy_pkg::BITH'(H_MAX) : energy_pkg::BITH'($random(seed) % 3);
            frame_rows[i].hscaling = max_vals ? '1 : energy_pkg::SCALING_BIT'($random(seed));
        end
    endtask

    // sigma is +1 for a set bit and -1 for a clear bit
    // running sum wraps at the frame width
    task automatic model_frame(input int nrows);
        int acc;
        int sum;
        sum     = 0;
        exp_ovf = 1'b0;
        for (int i = 0; i < nrows; i++) begin
            acc = int'(frame_rows[i].hbias) * int'(frame_rows[i].hscaling);
            for (int j = 0; j < energy_pkg::DATASPIN; j++) begin
                acc += (frame_spin[j] ? 1 : -1)
                     * int'($signed(frame_rows[i].j_row[j*energy_pkg::BITJ +: energy_pkg::BITJ]));
            end
            sum += frame_spin[i] ? acc : -acc;
            if (sum > E_MAX || sum < -E_MAX - 1) exp_ovf = 1'b1;
            sum = int'(energy_pkg::energy_t'(sum));
        end
        exp_energy = energy_pkg::energy_t'(sum);
    endtask

    task automatic wait_energy(input bit ack);
        int n;
        n = 0;
        energy_ready_i = ack;
        @(negedge clk_i);
        while (!energy_valid_o && n < TIMEOUT) begin
            n++;
            @(negedge clk_i);
        end
        checks++;
        assert (energy_valid_o) else begin
            $display("%s: energy_valid_o never rose", test_name);
            errors++;
        end
        got_energy = energy_o;
        got_ovf    = accum_overflow_o;
        @(posedge clk_i);
        #DRV;
        energy_ready_i = 1'b0;
    endtask

    task automatic check_frame(input int nrows);
        model_frame(nrows);
        check_value("energy_o", int'(exp_energy), int'(got_energy));
        check_value("accum_overflow_o", int'(exp_ovf), int'(got_ovf));
    endtask

    task automatic send_spin();
        spin_valid_i = 1'b1;
        spin_i       = frame_spin;
        wait_accept(1, "spin");
    endtask

    task automatic send_rows(input int nrows);
        while (row_next < nrows) begin
            weight_valid_i = 1'b1;
            weight_i       = frame_rows[row_next];
            wait_accept(2, "weight");
            row_next++;
        end
    endtask

    task automatic run_frame(input int nrows);
        send_spin();
        send_rows(nrows);
        wait_energy(1'b1);
        check_frame(nrows);
    endtask

    // keeps offering rows while the core is stalled and leaves valid high
    task automatic offer_rows(input int cycles, input logic exp_valid,
                              input energy_pkg::energy_t exp_e);
        weight_valid_i = 1'b1;
        weight_i       = frame_rows[row_next];
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk_i);
            check_value("stalled energy_valid_o", int'(exp_valid), int'(energy_valid_o));
            check_value("stalled energy_o", int'(exp_e), int'(energy_o));
            if (weight_ready_o) begin
                @(posedge clk_i);
                #DRV;
                row_next++;
                weight_i = frame_rows[row_next];
            end else begin
                @(posedge clk_i);
                #DRV;
            end
        end
        checks++;
        assert (!weight_ready_o) else begin
            $display("%s: weight_ready_o stayed high while the core was stalled", test_name);
            errors++;
        end
    endtask

    initial begin
        seed             = 32'h47c7;
        rst_i            = 1'b1;
        en_i             = 1'b1;
        config_valid_i   = 1'b0;
        config_counter_i = '0;
        spin_valid_i     = 1'b0;
        spin_i           = '0;
        weight_valid_i   = 1'b0;
        weight_i         = '0;
        energy_ready_i   = 1'b0;
        repeat (10) @(posedge clk_i);
        #DRV;
        rst_i = 1'b0;

        start_test("reset");
        @(negedge clk_i);
        check_value("energy_valid_o", 0, int'(energy_valid_o));
        check_value("accum_overflow_o", 0, int'(accum_overflow_o));
        wait_accept(0, "config"); // only ready is watched here
        end_test();

        start_test("full_frame");
        fill_frame(1'b0);
        run_frame(energy_pkg::DATASPIN);
        end_test();

        start_test("short_frame");
        config_valid_i   = 1'b1;
        config_counter_i = energy_pkg::SPINIDX_BIT'(3);
        wait_accept(0, "config");
        fill_frame(1'b0);
        run_frame(4);
        fill_frame(1'b0);
        run_frame(4); // must start from a cleared sum
        end_test();

        start_test("backpressure");
        fill_frame(1'b0);
        send_spin();
        send_rows(4);
        wait_energy(1'b0);
        check_frame(4);
        fill_frame(1'b0);
        offer_rows(8, 1'b1, exp_energy); // rows of the next frame pile up in the input stage
        wait_energy(1'b1);
        check_value("energy_o after stall", int'(exp_energy), int'(got_energy));
        run_frame(4);
        end_test();

        start_test("overflow");
        config_valid_i   = 1'b1;
        config_counter_i = energy_pkg::SPINIDX_BIT'(energy_pkg::DATASPIN - 1);
        wait_accept(0, "config");
        fill_frame(1'b1);
        run_frame(energy_pkg::DATASPIN);
        end_test();

        start_test("enable_low");
        fill_frame(1'b0);
        en_i = 1'b0;
        send_spin();
        offer_rows(8, 1'b0, '0); // sum was cleared by the last output transfer
        en_i = 1'b1;
        send_rows(energy_pkg::DATASPIN);
        wait_energy(1'b1);
        check_frame(energy_pkg::DATASPIN);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/energy_monitor.sv
/* Top of the energy monitor: registered input stages, frame control,
   local energy per row and the frame accumulator. */
`default_nettype none

module energy_monitor (
    input  wire logic                               clk_i,
    input  wire logic                               rst_i,
    input  wire logic                               en_i,

    input  wire logic                               config_valid_i,
    input  wire logic [energy_pkg::SPINIDX_BIT-1:0] config_counter_i, // last row index
    output logic                                    config_ready_o,

    input  wire logic                               spin_valid_i,
    input  wire energy_pkg::spin_vec_t              spin_i,
    output logic                                    spin_ready_o,

    input  wire logic                               weight_valid_i,
    input  wire energy_pkg::weight_row_t            weight_i,
    output logic                                    weight_ready_o,

    output logic                                    energy_valid_o,
    output energy_pkg::energy_t                     energy_o,
    output logic                                    accum_overflow_o,
    input  wire logic                               energy_ready_i
);

    logic                               cfg_valid, cfg_ready;
    logic [energy_pkg::SPINIDX_BIT-1:0] cfg_last;
    logic                               spin_valid, spin_ready;
    energy_pkg::spin_vec_t              spin_data;
    logic                               row_valid, row_ready;
    energy_pkg::weight_row_t            row_data;

    logic                               cfg_xfer, spin_xfer, row_xfer;
    logic [energy_pkg::SPINIDX_BIT-1:0] row_idx;
    logic                               last_row;
    energy_pkg::spin_vec_t              spins;
    logic                               current_spin;
    energy_pkg::local_energy_t          local_energy;

    assign cfg_xfer  = cfg_valid && cfg_ready;
    assign spin_xfer = spin_valid && spin_ready;
    assign row_xfer  = row_valid && row_ready;

    stream_stage #(.data_t(logic [energy_pkg::SPINIDX_BIT-1:0])) u_cfg_stage (
        .clk_i(clk_i), .rst_i(rst_i),
        .valid_i(config_valid_i), .ready_o(config_ready_o), .data_i(config_counter_i),
        .valid_o(cfg_valid), .ready_i(cfg_ready), .data_o(cfg_last)
    );

    stream_stage #(.data_t(energy_pkg::spin_vec_t)) u_spin_stage (
        .clk_i(clk_i), .rst_i(rst_i),
        .valid_i(spin_valid_i), .ready_o(spin_ready_o), .data_i(spin_i),
        .valid_o(spin_valid), .ready_i(spin_ready), .data_o(spin_data)
    );

    stream_stage #(.data_t(energy_pkg::weight_row_t)) u_row_stage (
        .clk_i(clk_i), .rst_i(rst_i),
        .valid_i(weight_valid_i), .ready_o(weight_ready_o), .data_i(weight_i),
        .valid_o(row_valid), .ready_i(row_ready), .data_o(row_data)
    );

    monitor_ctrl u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i), .en_i(en_i),
        .config_valid_i(cfg_valid), .config_ready_o(cfg_ready),
        .spin_valid_i(spin_valid), .spin_ready_o(spin_ready),
        .weight_valid_i(row_valid), .weight_ready_o(row_ready),
        .last_row_i(last_row),
        .energy_valid_i(energy_valid_o), .energy_ready_i(energy_ready_i)
    );

    row_counter u_row_counter (
        .clk_i(clk_i), .rst_i(rst_i),
        .config_load_i(cfg_xfer), .config_last_i(cfg_last),
        .restart_i(spin_xfer), .step_i(row_xfer),
        .row_idx_o(row_idx), .last_row_o(last_row)
    );

    spin_cache u_spin_cache (
        .clk_i(clk_i), .rst_i(rst_i),
        .load_i(spin_xfer), .spin_i(spin_data), .row_idx_i(row_idx),
        .spins_o(spins), .current_spin_o(current_spin)
    );

    local_energy_calc u_local_energy (
        .spins_i(spins), .current_spin_i(current_spin),
        .row_i(row_data), .energy_o(local_energy)
    );

    energy_accumulator u_accumulator (
        .clk_i(clk_i), .rst_i(rst_i),
        .valid_i(row_xfer), .last_i(last_row), .data_i(local_energy),
        .energy_valid_o(energy_valid_o), .energy_ready_i(energy_ready_i),
        .energy_o(energy_o), .overflow_o(accum_overflow_o)
    );

endmodule

`default_nettype wire

//--- design/energy_accumulator.sv
/* Frame energy accumulator with a wrapping sum and sticky overflow flag.
   Presents the sum after the last row and clears it on the output transfer. */
`default_nettype none

module energy_accumulator (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire logic                      valid_i,
    input  wire logic                      last_i,
    input  wire energy_pkg::local_energy_t data_i,
    output logic                           energy_valid_o,
    input  wire logic                      energy_ready_i,
    output energy_pkg::energy_t            energy_o,
    output logic                           overflow_o
);

    energy_pkg::energy_t sum_q;
    energy_pkg::energy_t addend;
    energy_pkg::energy_t sum_next;
    logic                ovf;
    logic                valid_q;
    logic                overflow_q;

    assign addend   = energy_pkg::energy_t'(data_i); // sign extension
    assign sum_next = sum_q + addend;
    // same-sign operands giving a result of the other sign
    assign ovf = (sum_q[$bits(sum_q)-1] == addend[$bits(addend)-1])
              && (sum_next[$bits(sum_next)-1] != sum_q[$bits(sum_q)-1]);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sum_q      <= '0;
            overflow_q <= 1'b0;
            valid_q    <= 1'b0;
        end else if (valid_q && energy_ready_i) begin
            sum_q      <= '0; // result taken, start fresh
            overflow_q <= 1'b0;
            valid_q    <= 1'b0;
        end else if (valid_i) begin
            sum_q      <= sum_next;
            overflow_q <= overflow_q || ovf;
            if (last_i) valid_q <= 1'b1;
        end
    end

    assign energy_valid_o = valid_q;
    assign energy_o       = sum_q;
    assign overflow_o     = overflow_q;

endmodule

`default_nettype wire

//--- design/local_energy_calc.sv
/* Local energy of one row: sigma_i * (sum_j J_ij*sigma_j + h_i*scale).
   Purely combinational, the couplings are summed in a binary tree. */
`default_nettype none

module local_energy_calc (
    input  wire energy_pkg::spin_vec_t   spins_i,
    input  wire logic                    current_spin_i,
    input  wire energy_pkg::weight_row_t row_i,
    output energy_pkg::local_energy_t    energy_o
);

    // level 0 holds the signed terms, the last level holds the row sum
    energy_pkg::local_energy_t tree [$clog2(energy_pkg::DATASPIN)+1][energy_pkg::DATASPIN];
    energy_pkg::local_energy_t bias_term;
    energy_pkg::local_energy_t total;

    always_comb begin
        for (int l = 0; l <= $clog2(energy_pkg::DATASPIN); l++) begin
            for (int i = 0; i < energy_pkg::DATASPIN; i++) begin
                tree[l][i] = '0;
            end
        end
        for (int j = 0; j < energy_pkg::DATASPIN; j++) begin
            tree[0][j] = energy_pkg::local_energy_t'(
                $signed(row_i.j_row[j*energy_pkg::BITJ +: energy_pkg::BITJ]));
            if (!spins_i[j]) tree[0][j] = -tree[0][j]; // sigma_j = -1
        end
        for (int l = 1; l <= $clog2(energy_pkg::DATASPIN); l++) begin
            for (int i = 0; i < (energy_pkg::DATASPIN >> l); i++) begin
                tree[l][i] = tree[l-1][2*i] + tree[l-1][2*i+1];
            end
        end
    end

    // scale is unsigned, zero-extend before the signed multiply
    assign bias_term = energy_pkg::local_energy_t'(row_i.hbias)
                     * energy_pkg::local_energy_t'($signed({1'b0, row_i.hscaling}));

    assign total    = tree[$clog2(energy_pkg::DATASPIN)][0] + bias_term;
    assign energy_o = current_spin_i ? total : -total; // sigma_i = -1 flips sign

endmodule

`default_nettype wire

//--- design/spin_cache.sv
/* Holds the spin vector of the running frame and picks the spin of the
   row being processed. */
`default_nettype none

module spin_cache (
    input  wire logic                               clk_i,
    input  wire logic                               rst_i,
    input  wire logic                               load_i,
    input  wire energy_pkg::spin_vec_t              spin_i,
    input  wire logic [energy_pkg::SPINIDX_BIT-1:0] row_idx_i,
    output energy_pkg::spin_vec_t                   spins_o,
    output logic                                    current_spin_o
);

    energy_pkg::spin_vec_t spins_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            spins_q <= '0;
        end else if (load_i) begin
            spins_q <= spin_i; // kept for the whole frame
        end
    end

    assign spins_o        = spins_q;
    assign current_spin_o = spins_q[row_idx_i]; // sigma_i of this row

endmodule

`default_nettype wire

//--- design/row_counter.sv
/* Row index of the current frame and the configured last row index.
   The last index survives across frames until the next config transfer. */
`default_nettype none

module row_counter (
    input  wire logic                                  clk_i,
    input  wire logic                                  rst_i,
    input  wire logic                                  config_load_i,
    input  wire logic [energy_pkg::SPINIDX_BIT-1:0]    config_last_i,
    input  wire logic                                  restart_i,
    input  wire logic                                  step_i,
    output logic [energy_pkg::SPINIDX_BIT-1:0]         row_idx_o,
    output logic                                       last_row_o
);

    logic [energy_pkg::SPINIDX_BIT-1:0] last_q;
    logic [energy_pkg::SPINIDX_BIT-1:0] idx_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_q <= energy_pkg::SPINIDX_BIT'(energy_pkg::DATASPIN - 1); // full frame
        end else if (config_load_i) begin
            last_q <= config_last_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            idx_q <= '0;
        end else if (restart_i) begin
            idx_q <= '0; // new spin vector, new frame
        end else if (step_i) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign row_idx_o  = idx_q;
    assign last_row_o = (idx_q == last_q);

endmodule

`default_nettype wire

//--- design/monitor_ctrl.sv
/* Frame FSM of the energy monitor: IDLE takes config and spins, ROWS takes
   weight rows, OUT waits for the energy transfer. */
`default_nettype none

module monitor_ctrl (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic en_i,
    input  wire logic config_valid_i,
    output logic      config_ready_o,
    input  wire logic spin_valid_i,
    output logic      spin_ready_o,
    input  wire logic weight_valid_i,
    output logic      weight_ready_o,
    input  wire logic last_row_i,
    input  wire logic energy_valid_i,
    input  wire logic energy_ready_i
);

    typedef enum logic [1:0] {
        IDLE,
        ROWS,
        OUT
    } state_t;

    state_t state_q;

    assign config_ready_o = en_i && (state_q == IDLE);
    // a pending config goes in before the spins of the next frame
    assign spin_ready_o   = en_i && (state_q == IDLE) && !config_valid_i;
    assign weight_ready_o = en_i && (state_q == ROWS);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (spin_valid_i && spin_ready_o) state_q <= ROWS;
                ROWS: begin
                    if (weight_valid_i && weight_ready_o && last_row_i) begin
                        state_q <= OUT; // final row of the frame
                    end
                end
                OUT:  if (energy_valid_i && energy_ready_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/stream_stage.sv
/* Registered valid/ready stage with a skid slot, placed on each input.
   Output is valid one cycle after the input transfer; ready_o is a flop. */
`default_nettype none

module stream_stage #(
    parameter type data_t = logic
) (
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    input  wire logic  valid_i,
    output logic       ready_o,
    input  wire data_t data_i,
    output logic       valid_o,
    input  wire logic  ready_i,
    output data_t      data_o
);

    logic  main_valid_q;
    data_t main_data_q;
    logic  skid_valid_q;
    data_t skid_data_q;
    logic  in_xfer;

    assign in_xfer = valid_i && ready_o;
    assign ready_o = !skid_valid_q; // taken only while skid slot is empty
    assign valid_o = main_valid_q;
    assign data_o  = main_data_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            main_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (!main_valid_q || ready_i) begin
            // main slot frees up on this edge
            if (skid_valid_q) begin
                main_data_q  <= skid_data_q;
                main_valid_q <= 1'b1;
                skid_valid_q <= 1'b0;
            end else begin
                main_valid_q <= in_xfer;
                if (in_xfer) main_data_q <= data_i;
            end
        end else if (in_xfer) begin
            skid_data_q  <= data_i; // downstream stalled, park the beat
            skid_valid_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/energy_pkg.sv
/* Sizes and shared types of the Ising energy monitor.
   Referenced by scoped names from the RTL and the testbench. */
`default_nettype none

package energy_pkg;

    localparam int DATASPIN         = 16; // spins per vector
    localparam int BITJ             = 4;  // signed coupling width
    localparam int BITH             = 4;  // signed bias width
    localparam int SCALING_BIT      = 5;  // unsigned bias scale width
    localparam int LOCAL_ENERGY_BIT = 10;
    localparam int ENERGY_TOTAL_BIT = 12; // small so overflow is reachable
    localparam int SPINIDX_BIT      = 4;  // row index width

    // one bit per spin, 1 means +1 and 0 means -1
    typedef logic [DATASPIN-1:0] spin_vec_t;

    // coupling j of the row sits at bit j*BITJ
    typedef struct packed {
        logic [DATASPIN*BITJ-1:0]  j_row;
        logic signed [BITH-1:0]    hbias;
        logic [SCALING_BIT-1:0]    hscaling;
    } weight_row_t;

    typedef logic signed [LOCAL_ENERGY_BIT-1:0] local_energy_t;
    typedef logic signed [ENERGY_TOTAL_BIT-1:0] energy_t;

endpackage

`default_nettype wire
